/* spm_params.svh */
`ifndef SPM_PARAMS_SVH
`define SPM_PARAMS_SVH

// number of protected-module slots in the controller
`define SPM_NB_SLOTS 4

// the ID counter starts here after reset
`define SPM_ID_FIRST 16'h0001
// once next_id reaches this value no further module can be enabled
`define SPM_ID_LIMIT 16'hfff0

// word addresses of the configuration port
`define SPM_REG_PUB_START 3'd0
`define SPM_REG_PUB_END   3'd1
`define SPM_REG_SEC_START 3'd2
`define SPM_REG_SEC_END   3'd3
`define SPM_REG_CMD       3'd4
`define SPM_REG_STATUS    3'd5
`define SPM_REG_LAST_ID   3'd6

// codes written to the command register
`define SPM_CMD_ENABLE  16'd1
`define SPM_CMD_DISABLE 16'd2

`endif

/* spm_pkg.sv */
`default_nettype none

`include "spm_params.svh"

package spm_pkg;

  // byte address on the core side and in the layout registers
  typedef logic [15:0] spm_addr_t;

  // module ID, zero stands for "no module"
  typedef logic [15:0] spm_id_t;

  // one bit per slot
  typedef logic [`SPM_NB_SLOTS-1:0] slot_mask_t;

  // word address of the configuration registers
  typedef logic [2:0] wb_addr_t;

  // configuration command sequencing
  typedef enum logic [2:0]
  {
    IDLE,
    CHECK,
    COMMIT,
    REJECT,
    ACK
  } cfg_state_t;

endpackage

`default_nettype wire

/* spm_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_slot (
  input  wire                  mclk,
  input  wire                  puc_rst,
  input  wire spm_pkg::spm_addr_t pc,
  input  wire spm_pkg::spm_addr_t prev_pc,
  input  wire spm_pkg::spm_addr_t eu_mab,
  input  wire                  eu_mb_en,
  input  wire                  update,
  input  wire                  disable_req,
  input  wire spm_pkg::spm_addr_t new_pub_start,
  input  wire spm_pkg::spm_addr_t new_pub_end,
  input  wire spm_pkg::spm_addr_t new_sec_start,
  input  wire spm_pkg::spm_addr_t new_sec_end,
  input  wire spm_pkg::spm_id_t   new_id,
  output logic                 enabled,
  output logic                 executing,
  output logic                 violation,
  output logic                 overlap,
  output spm_pkg::spm_id_t     id
);

  import spm_pkg::*;

  spm_addr_t pub_start;
  spm_addr_t pub_end;
  spm_addr_t sec_start;
  spm_addr_t sec_end;
  logic      pc_in_pub;
  logic      prev_in_pub;
  logic      mab_in_sec;
  logic      sec_access;
  logic      bad_entry;

  // two half-open ranges share at least one address
  function automatic logic intersects(input spm_addr_t a_start, input spm_addr_t a_end,
                                      input spm_addr_t b_start, input spm_addr_t b_end);
    intersects = (a_start < a_end) && (b_start < b_end) &&
                 (a_start < b_end) && (b_start < a_end);
  endfunction

  // layout and ID are only meaningful while enabled is set
  always_ff @(posedge mclk)
  begin
    if (update)
    begin
      pub_start <= new_pub_start;
      pub_end   <= new_pub_end;
      sec_start <= new_sec_start;
      sec_end   <= new_sec_end;
      id        <= new_id;
    end
  end

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      enabled <= 1'b0;
    end
    else if (update)
    begin
      enabled <= 1'b1;
    end
    // a disable only hits the module that holds the pc
    else if (disable_req && executing)
    begin
      enabled <= 1'b0;
    end
  end

  assign pc_in_pub   = (pc >= pub_start) && (pc < pub_end);
  assign prev_in_pub = (prev_pc >= pub_start) && (prev_pc < pub_end);
  assign mab_in_sec  = (eu_mab >= sec_start) && (eu_mab < sec_end);

  assign executing = enabled && pc_in_pub;

  // secret data may only be touched by the owner's own code
  assign sec_access = enabled && eu_mb_en && mab_in_sec && !executing;

  // coming from outside, the only legal target is the entry point
  assign bad_entry = enabled && !prev_in_pub && pc_in_pub && (pc != pub_start);

  assign violation = sec_access || bad_entry;

  assign overlap = enabled &&
                   (intersects(new_pub_start, new_pub_end, pub_start, pub_end) ||
                    intersects(new_pub_start, new_pub_end, sec_start, sec_end) ||
                    intersects(new_sec_start, new_sec_end, pub_start, pub_end) ||
                    intersects(new_sec_start, new_sec_end, sec_start, sec_end));

  // the allocator must only ever pick a free slot
  a_update_free: assert property (@(posedge mclk) disable iff (puc_rst)
    update |-> !enabled);

endmodule

`default_nettype wire

/* spm_id_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spm_params.svh"

module spm_id_counter (
  input  wire              mclk,
  input  wire              puc_rst,
  input  wire              id_take,
  output spm_pkg::spm_id_t next_id,
  output logic             id_exhausted
);

  import spm_pkg::*;

  // IDs are handed out in increasing order and never reused
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      next_id <= `SPM_ID_FIRST;
    end
    else if (id_take)
    begin
      next_id <= next_id + spm_id_t'(1);
    end
  end

  assign id_exhausted = (next_id == `SPM_ID_LIMIT);

  // the command FSM rejects enables once the IDs run out
  a_no_take_exhausted: assert property (@(posedge mclk) disable iff (puc_rst)
    id_take |-> !id_exhausted);

endmodule

`default_nettype wire

/* spm_cfg_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spm_params.svh"

module spm_cfg_fsm (
  input  wire                     mclk,
  input  wire                     puc_rst,
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire spm_pkg::wb_addr_t  wb_adr,
  input  wire [15:0]              wb_dat_w,
  output logic                    wb_ack,
  output logic [15:0]             wb_dat_r,
  input  wire                     layout_conflict,
  input  wire                     slots_full,
  input  wire                     any_enabled,
  input  wire                     exec_sm,
  input  wire                     violation,
  input  wire spm_pkg::spm_id_t   next_id,
  input  wire                     id_exhausted,
  output spm_pkg::spm_addr_t      new_pub_start,
  output spm_pkg::spm_addr_t      new_pub_end,
  output spm_pkg::spm_addr_t      new_sec_start,
  output spm_pkg::spm_addr_t      new_sec_end,
  output logic                    commit_enable,
  output logic                    commit_disable,
  output logic                    id_take
);

  import spm_pkg::*;

  cfg_state_t state;
  cfg_state_t state_nxt;
  wb_addr_t   req_adr;
  logic       is_enable;
  logic       wait_low;
  logic       accept;
  logic       cmd_write;
  logic       enable_ok;
  logic       check_ok;
  logic       last_result;
  spm_id_t    last_id;

  // a new bus cycle is only taken once the previous strobe has gone away
  assign accept = wb_cyc && wb_stb && !wait_low && (state == IDLE);
  assign cmd_write = wb_we && (wb_adr == `SPM_REG_CMD) &&
                     ((wb_dat_w == `SPM_CMD_ENABLE) || (wb_dat_w == `SPM_CMD_DISABLE));

  assign enable_ok = !layout_conflict && !slots_full && !id_exhausted &&
                     (new_pub_end > new_pub_start);
  assign check_ok  = is_enable ? enable_ok : exec_sm;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (accept)
        begin
          state_nxt = cmd_write ? CHECK : ACK;
        end
      end
      CHECK:          state_nxt = check_ok ? COMMIT : REJECT;
      COMMIT, REJECT: state_nxt = ACK;
      default:        state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      state       <= IDLE;
      wait_low    <= 1'b0;
      last_result <= 1'b0;
      last_id     <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (state == ACK)
      begin
        wait_low <= 1'b1;
      end
      else if (!wb_stb)
      begin
        wait_low <= 1'b0;
      end
      if (state == COMMIT)
      begin
        last_result <= 1'b1;
      end
      else if (state == REJECT)
      begin
        last_result <= 1'b0;
      end
      if (commit_enable)
      begin
        last_id <= next_id;
      end
    end
  end

  // staged layout, written by software before a command
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      new_pub_start <= '0;
      new_pub_end   <= '0;
      new_sec_start <= '0;
      new_sec_end   <= '0;
    end
    else if (accept && wb_we)
    begin
      case (wb_adr)
        `SPM_REG_PUB_START: new_pub_start <= wb_dat_w;
        `SPM_REG_PUB_END:   new_pub_end   <= wb_dat_w;
        `SPM_REG_SEC_START: new_sec_start <= wb_dat_w;
        `SPM_REG_SEC_END:   new_sec_end   <= wb_dat_w;
        default:            ;
      endcase
    end
  end

  // request details are kept for the rest of the bus cycle
  always_ff @(posedge mclk)
  begin
    if (accept)
    begin
      req_adr   <= wb_adr;
      is_enable <= (wb_dat_w == `SPM_CMD_ENABLE);
    end
  end

  always_comb
  begin
    case (req_adr)
      `SPM_REG_PUB_START: wb_dat_r = new_pub_start;
      `SPM_REG_PUB_END:   wb_dat_r = new_pub_end;
      `SPM_REG_SEC_START: wb_dat_r = new_sec_start;
      `SPM_REG_SEC_END:   wb_dat_r = new_sec_end;
      `SPM_REG_STATUS:    wb_dat_r = {13'b0, violation, any_enabled, last_result};
      `SPM_REG_LAST_ID:   wb_dat_r = last_id;
      default:            wb_dat_r = '0;
    endcase
  end

  assign wb_ack         = (state == ACK);
  assign commit_enable  = (state == COMMIT) && is_enable;
  assign commit_disable = (state == COMMIT) && !is_enable;
  assign id_take        = commit_enable;

  a_ack_single: assert property (@(posedge mclk) disable iff (puc_rst)
    wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* spm_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spm_params.svh"

module spm_control (
  input  wire                     mclk,
  input  wire                     puc_rst,
  input  wire spm_pkg::spm_addr_t pc,
  input  wire spm_pkg::spm_addr_t prev_pc,
  input  wire spm_pkg::spm_addr_t eu_mab,
  input  wire                     eu_mb_en,
  input  wire                     commit_enable,
  input  wire                     commit_disable,
  input  wire spm_pkg::spm_addr_t new_pub_start,
  input  wire spm_pkg::spm_addr_t new_pub_end,
  input  wire spm_pkg::spm_addr_t new_sec_start,
  input  wire spm_pkg::spm_addr_t new_sec_end,
  input  wire spm_pkg::spm_id_t   next_id,
  input  wire                     id_exhausted,
  output logic                    layout_conflict,
  output logic                    slots_full,
  output logic                    any_enabled,
  output logic                    exec_sm,
  output logic                    enter_sm,
  output logic                    violation,
  output spm_pkg::spm_id_t        spm_current_id,
  output spm_pkg::spm_id_t        spm_prev_id
);

  import spm_pkg::*;

  slot_mask_t slot_enabled;
  slot_mask_t slot_executing;
  slot_mask_t slot_violation;
  slot_mask_t slot_overlap;
  slot_mask_t slot_update;
  slot_mask_t first_free;
  logic       found_free;
  spm_id_t    slot_id [`SPM_NB_SLOTS];
  spm_id_t    prev_cycle_id;

  // one-hot pick of the lowest disabled slot
  always_comb
  begin
    first_free = '0;
    found_free = 1'b0;
    for (int i = 0; i < `SPM_NB_SLOTS; i++)
    begin
      if (!slot_enabled[i] && !found_free)
      begin
        first_free[i] = 1'b1;
        found_free    = 1'b1;
      end
    end
  end

  assign slot_update = first_free & {`SPM_NB_SLOTS{commit_enable}};

  genvar g;
  generate
    for (g = 0; g < `SPM_NB_SLOTS; g++)
    begin : g_slot
      spm_slot u_slot (
        .mclk          (mclk),
        .puc_rst       (puc_rst),
        .pc            (pc),
        .prev_pc       (prev_pc),
        .eu_mab        (eu_mab),
        .eu_mb_en      (eu_mb_en),
        .update        (slot_update[g]),
        .disable_req   (commit_disable),
        .new_pub_start (new_pub_start),
        .new_pub_end   (new_pub_end),
        .new_sec_start (new_sec_start),
        .new_sec_end   (new_sec_end),
        .new_id        (next_id),
        .enabled       (slot_enabled[g]),
        .executing     (slot_executing[g]),
        .violation     (slot_violation[g]),
        .overlap       (slot_overlap[g]),
        .id            (slot_id[g])
      );
    end
  endgenerate

  assign layout_conflict = |slot_overlap;
  assign slots_full      = &slot_enabled;
  assign any_enabled     = |slot_enabled;
  assign exec_sm         = |slot_executing;
  // running out of IDs is reported like any other violation
  assign violation       = (|slot_violation) || id_exhausted;

  always_comb
  begin
    spm_current_id = '0;
    for (int i = 0; i < `SPM_NB_SLOTS; i++)
    begin
      if (slot_executing[i])
      begin
        spm_current_id = slot_id[i];
      end
    end
  end

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      prev_cycle_id <= '0;
      spm_prev_id   <= '0;
    end
    else
    begin
      prev_cycle_id <= spm_current_id;
      // remember which module was left on every switch
      if (prev_cycle_id != spm_current_id)
      begin
        spm_prev_id <= prev_cycle_id;
      end
    end
  end

  // leaving a module for unprotected code is not an entry
  assign enter_sm = (prev_cycle_id != spm_current_id) && (spm_current_id != 16'h0000);

  // overlap checks at enable time keep the public ranges disjoint
  a_exec_onehot: assert property (@(posedge mclk) disable iff (puc_rst)
    $onehot0(slot_executing));

endmodule

`default_nettype wire

/* spm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spm_top (
  input  wire                     mclk,
  input  wire                     puc_rst,
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire spm_pkg::wb_addr_t  wb_adr,
  input  wire [15:0]              wb_dat_w,
  output logic                    wb_ack,
  output logic [15:0]             wb_dat_r,
  input  wire spm_pkg::spm_addr_t pc,
  input  wire spm_pkg::spm_addr_t prev_pc,
  input  wire spm_pkg::spm_addr_t eu_mab,
  input  wire                     eu_mb_en,
  output logic                    exec_sm,
  output logic                    enter_sm,
  output logic                    violation,
  output spm_pkg::spm_id_t        spm_current_id,
  output spm_pkg::spm_id_t        spm_prev_id
);

  import spm_pkg::*;

  spm_addr_t new_pub_start;
  spm_addr_t new_pub_end;
  spm_addr_t new_sec_start;
  spm_addr_t new_sec_end;
  spm_id_t   next_id;
  logic      commit_enable;
  logic      commit_disable;
  logic      id_take;
  logic      id_exhausted;
  logic      layout_conflict;
  logic      slots_full;
  logic      any_enabled;

  spm_cfg_fsm u_cfg_fsm (
    .mclk            (mclk),
    .puc_rst         (puc_rst),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_ack          (wb_ack),
    .wb_dat_r        (wb_dat_r),
    .layout_conflict (layout_conflict),
    .slots_full      (slots_full),
    .any_enabled     (any_enabled),
    .exec_sm         (exec_sm),
    .violation       (violation),
    .next_id         (next_id),
    .id_exhausted    (id_exhausted),
    .new_pub_start   (new_pub_start),
    .new_pub_end     (new_pub_end),
    .new_sec_start   (new_sec_start),
    .new_sec_end     (new_sec_end),
    .commit_enable   (commit_enable),
    .commit_disable  (commit_disable),
    .id_take         (id_take)
  );

  spm_id_counter u_id_counter (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .id_take      (id_take),
    .next_id      (next_id),
    .id_exhausted (id_exhausted)
  );

  spm_control u_control (
    .mclk            (mclk),
    .puc_rst         (puc_rst),
    .pc              (pc),
    .prev_pc         (prev_pc),
    .eu_mab          (eu_mab),
    .eu_mb_en        (eu_mb_en),
    .commit_enable   (commit_enable),
    .commit_disable  (commit_disable),
    .new_pub_start   (new_pub_start),
    .new_pub_end     (new_pub_end),
    .new_sec_start   (new_sec_start),
    .new_sec_end     (new_sec_end),
    .next_id         (next_id),
    .id_exhausted    (id_exhausted),
    .layout_conflict (layout_conflict),
    .slots_full      (slots_full),
    .any_enabled     (any_enabled),
    .exec_sm         (exec_sm),
    .enter_sm        (enter_sm),
    .violation       (violation),
    .spm_current_id  (spm_current_id),
    .spm_prev_id     (spm_prev_id)
  );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int half_period = 5
) (
  output logic mclk
);

  // free-running clock, 10 ns period with the default half period
  initial
  begin
    mclk = 1'b0;
  end

  always
  begin
    #half_period;
    mclk = ~mclk;
  end

endmodule

`default_nettype wire

/* spm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spm_params.svh"

module spm_tb;

  localparam logic [1:0] op_write = 2'd0;
  localparam logic [1:0] op_read  = 2'd1;
  localparam logic [1:0] op_step  = 2'd2;

  // data holds the write value of a bus write or the expected value of a bus read
  typedef struct packed {
    logic [1:0]  op;
    logic [2:0]  adr;
    logic [15:0] data;
    logic [15:0] pc;
    logic [15:0] prev_pc;
    logic [15:0] mab;
    logic        mb_en;
    logic        rnd_mab;
    logic        exp_exec;
    logic        exp_enter;
    logic        exp_viol;
    logic [15:0] exp_cur;
    logic [15:0] exp_prev;
  } row_t;

  logic        mclk;
  logic        puc_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [15:0] wb_dat_w;
  logic        wb_ack;
  logic [15:0] wb_dat_r;
  logic [15:0] pc;
  logic [15:0] prev_pc;
  logic [15:0] eu_mab;
  logic        eu_mb_en;
  logic        exec_sm;
  logic        enter_sm;
  logic        violation;
  logic [15:0] spm_current_id;
  logic [15:0] spm_prev_id;

  row_t rows[$];

  tb_clkgen u_clkgen (
    .mclk (mclk)
  );

  spm_top i_spm_top (
    .mclk           (mclk),
    .puc_rst        (puc_rst),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_ack         (wb_ack),
    .wb_dat_r       (wb_dat_r),
    .pc             (pc),
    .prev_pc        (prev_pc),
    .eu_mab         (eu_mab),
    .eu_mb_en       (eu_mb_en),
    .exec_sm        (exec_sm),
    .enter_sm       (enter_sm),
    .violation      (violation),
    .spm_current_id (spm_current_id),
    .spm_prev_id    (spm_prev_id)
  );

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // runs one Wishbone classic cycle and releases the strobe in the cycle after the ack
  task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [15:0] wdata,
                           output logic [15:0] rdata);
    int   cycles;
    logic got_ack;
    @(posedge mclk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    cycles   = 0;
    got_ack  = 1'b0;
    rdata    = 16'h0000;
    while (!got_ack && cycles < 20)
    begin
      @(posedge mclk);
      #1;
      cycles++;
      got_ack = wb_ack;
    end
    if (!got_ack)
    begin
      $display("Bus timeout: no wb_ack within 20 cycles for register %0d", adr);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bus cycle timed out");
    end
    else
    begin
      rdata = wb_dat_r;
      @(posedge mclk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  // core outputs are combinational, so they are sampled mid-cycle
  task automatic core_step(input row_t r);
    logic [15:0] mab;
    if (r.rnd_mab)
    begin
      mab = 16'hc000 | 16'($urandom() & 32'h0000_0fff);
    end
    else
    begin
      mab = r.mab;
    end
    @(posedge mclk);
    #1;
    pc       = r.pc;
    prev_pc  = r.prev_pc;
    eu_mab   = mab;
    eu_mb_en = r.mb_en;
    #4;
    check_value("exec_sm", 16'(exec_sm), 16'(r.exp_exec));
    check_value("enter_sm", 16'(enter_sm), 16'(r.exp_enter));
    check_value("violation", 16'(violation), 16'(r.exp_viol));
    check_value("spm_current_id", spm_current_id, r.exp_cur);
    check_value("spm_prev_id", spm_prev_id, r.exp_prev);
  endtask

  task automatic add_write(input logic [2:0] adr, input logic [15:0] data);
    row_t r;
    r      = '0;
    r.op   = op_write;
    r.adr  = adr;
    r.data = data;
    rows.push_back(r);
  endtask

  task automatic add_read(input logic [2:0] adr, input logic [15:0] expected);
    row_t r;
    r      = '0;
    r.op   = op_read;
    r.adr  = adr;
    r.data = expected;
    rows.push_back(r);
  endtask

  task automatic add_layout(input logic [15:0] pub_start, input logic [15:0] pub_end,
                            input logic [15:0] sec_start, input logic [15:0] sec_end);
    add_write(`SPM_REG_PUB_START, pub_start);
    add_write(`SPM_REG_PUB_END, pub_end);
    add_write(`SPM_REG_SEC_START, sec_start);
    add_write(`SPM_REG_SEC_END, sec_end);
  endtask

  task automatic add_step(input logic [15:0] step_pc, input logic [15:0] step_prev,
                          input logic [15:0] mab, input logic mb_en, input logic rnd_mab,
                          input logic exp_exec, input logic exp_enter, input logic exp_viol,
                          input logic [15:0] exp_cur, input logic [15:0] exp_prev);
    row_t r;
    r           = '0;
    r.op        = op_step;
    r.pc        = step_pc;
    r.prev_pc   = step_prev;
    r.mab       = mab;
    r.mb_en     = mb_en;
    r.rnd_mab   = rnd_mab;
    r.exp_exec  = exp_exec;
    r.exp_enter = exp_enter;
    r.exp_viol  = exp_viol;
    r.exp_cur   = exp_cur;
    r.exp_prev  = exp_prev;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // the status word holds violation, any enabled and last result from bit 2 down
    add_read(`SPM_REG_STATUS, 16'h0000);
    add_layout(16'h1000, 16'h1100, 16'h2000, 16'h2100);
    add_read(`SPM_REG_PUB_START, 16'h1000);
    add_read(`SPM_REG_PUB_END, 16'h1100);
    add_read(`SPM_REG_SEC_START, 16'h2000);
    add_read(`SPM_REG_SEC_END, 16'h2100);
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0003);
    add_read(`SPM_REG_LAST_ID, 16'd1);
    add_layout(16'h3000, 16'h3100, 16'h4000, 16'h4100);
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0003);
    add_read(`SPM_REG_LAST_ID, 16'd2);
    // this one overlaps the public range of ID 1
    add_layout(16'h1080, 16'h1200, 16'h5000, 16'h5100);
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0002);
    add_read(`SPM_REG_LAST_ID, 16'd2);
    add_layout(16'h6000, 16'h6100, 16'h7000, 16'h7100);
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0003);
    add_read(`SPM_REG_LAST_ID, 16'd3);
    add_layout(16'h8000, 16'h8100, 16'h9000, 16'h9100);
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0003);
    add_read(`SPM_REG_LAST_ID, 16'd4);
    // every slot is taken now
    add_layout(16'ha000, 16'ha100, 16'hb000, 16'hb100);
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0002);
    add_read(`SPM_REG_LAST_ID, 16'd4);
    // a step row gives pc, prev_pc, mab, mb_en and random mab, then exec, enter, viol, cur, prev
    add_step(16'h1000, 16'h0ffe, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd1, 16'd0);
    add_step(16'h1002, 16'h1000, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'd1, 16'd0);
    add_step(16'h0200, 16'h1002, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0, 16'd0);
    add_step(16'h0202, 16'h0200, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0, 16'd1);
    add_step(16'h0204, 16'h0202, 16'h2010, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'd0, 16'd1);
    add_step(16'h1000, 16'h0204, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd1, 16'd1);
    add_step(16'h1002, 16'h1000, 16'h2010, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 16'd1, 16'd0);
    add_step(16'h1004, 16'h1002, 16'h4020, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 16'd1, 16'd0);
    add_step(16'h0300, 16'h1004, 16'h0000, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 16'd0, 16'd0);
    // jump into the middle of ID 2
    add_step(16'h3050, 16'h0300, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 16'd2, 16'd1);
    add_step(16'h0400, 16'h3050, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0, 16'd0);
    add_step(16'h3000, 16'h0400, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd2, 16'd2);
    add_write(`SPM_REG_CMD, `SPM_CMD_DISABLE);
    add_read(`SPM_REG_STATUS, 16'h0003);
    add_step(16'h3002, 16'h3000, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0, 16'd2);
    // nothing is executing, so this disable is refused
    add_write(`SPM_REG_CMD, `SPM_CMD_DISABLE);
    add_read(`SPM_REG_STATUS, 16'h0002);
    add_step(16'h1000, 16'h3002, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd1, 16'd2);
    add_write(`SPM_REG_CMD, `SPM_CMD_DISABLE);
    add_step(16'h6000, 16'h1000, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd3, 16'd1);
    add_write(`SPM_REG_CMD, `SPM_CMD_DISABLE);
    add_step(16'h8000, 16'h6000, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd4, 16'd3);
    add_write(`SPM_REG_CMD, `SPM_CMD_DISABLE);
    add_read(`SPM_REG_STATUS, 16'h0001);
    // the staged layout is still the refused one and the IDs keep counting up
    add_write(`SPM_REG_CMD, `SPM_CMD_ENABLE);
    add_read(`SPM_REG_STATUS, 16'h0003);
    add_read(`SPM_REG_LAST_ID, 16'd5);
  endtask

  initial
  begin
    int unsigned seed_val;
    row_t        r;
    logic [15:0] rdata;
    puc_rst  = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 3'd0;
    wb_dat_w = 16'h0000;
    pc       = 16'h0000;
    prev_pc  = 16'h0000;
    eu_mab   = 16'h0000;
    eu_mb_en = 1'b0;
    seed_val = $urandom(3);
    build_table();
    repeat (4) @(posedge mclk);
    #1;
    puc_rst = 1'b0;
    for (int i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      case (r.op)
        op_write: bus_cycle(1'b1, r.adr, r.data, rdata);
        op_read:
        begin
          bus_cycle(1'b0, r.adr, 16'h0000, rdata);
          check_value($sformatf("wb_dat_r(reg %0d)", r.adr), rdata, r.data);
        end
        default: core_step(r);
      endcase
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
spm_pkg.sv
spm_slot.sv
spm_id_counter.sv
spm_cfg_fsm.sv
spm_control.sv
spm_top.sv
tb_clkgen.sv
spm_tb.sv

/* run.sh */
#!/bin/sh
# builds the protected-module controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module spm_tb -o spm_sim

# a failing check ends the simulator with a non-zero status, so keep going to the log
./obj_dir/spm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
